// ==== flist.f ====
common/clockDisplayPkg.sv
vgaTiming/vgaTiming.sv
overlay/digitFieldLocator.sv
overlay/segmentGlyph.sv
verilog/pixelCompositor.sv
verilog/clockDisplayTop.sv
sim/tbClockDisplay.sv

// ==== Makefile ====
TOP = tbClockDisplay

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f flist.f --top-module $(TOP) -o simv

run: build
	./obj_dir/simv | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== sim/tbClockDisplay.sv ====
// Clock display testbench
`timescale 1ns/10ps

module tbClockDisplay;

	localparam int lineCycles = 800;	// Default line length
	localparam int frameLines = 525;	// Lines per frame
	localparam int frameCycles = 420000;	// 525 lines of 800
	localparam int timeoutCycles = 5 * frameCycles + 4;	// Five frames plus reset
	localparam int rowTops [3] = '{21, 71, 141};	// Panel relative
	localparam int colLefts [6] = '{21, 46, 81, 106, 141, 166};
	localparam logic [11:0] rowColors [3] = '{12'hFFF, 12'h0F0, 12'hFA0};	// Date, time, timer

	logic CLK;
	logic rstN;
	logic [8:0][7:0] curBytes;	// Byte 0 is day and byte 8 is timer second
	clockDisplayPkg::rgbColor colorOut;
	logic hSyncN;
	logic vSyncN;
	logic videoOn;
	clockDisplayPkg::pixelCoord pixelX;
	clockDisplayPkg::pixelCoord pixelY;

	logic [17:0] lfsrState;	// Stimulus source
	string testName;	// Frame under test
	logic checking;	// Monitors enabled after reset
	int cycleCount = 0;
	int resetErrors = 0;
	int timingErrors = 0;
	int colorErrors = 0;
	int otherErrors = 0;
	bit digitSeen [10];	// Digit values drawn so far
	int invalidPixels = 0;	// Pixels checked in cells above nine

	logic prevH = 1'b1;	// Raster monitor state
	logic prevV = 1'b1;
	logic prevVideo = 1'b0;
	int hLowRun = 0;
	int hPeriod = 0;
	int hPulses = 0;	// Horizontal pulses since last vertical pulse
	int vLowRun = 0;
	int vPeriod = 0;
	int activeRun = 0;
	int activeLines = 0;
	int expX = 0;	// Expected coordinates
	int expY = 0;
	bit hFallSeen = 1'b0;
	bit vFallSeen = 1'b0;

	clockDisplayTop UUT (
		.CLK(CLK), .rstN(rstN),
		.dayBcd(curBytes[0]), .monthBcd(curBytes[1]), .yearBcd(curBytes[2]),
		.hourBcd(curBytes[3]), .minuteBcd(curBytes[4]), .secondBcd(curBytes[5]),
		.timerHourBcd(curBytes[6]), .timerMinuteBcd(curBytes[7]),
		.timerSecondBcd(curBytes[8]),
		.colorOut(colorOut), .hSyncN(hSyncN), .vSyncN(vSyncN),
		.videoOn(videoOn), .pixelX(pixelX), .pixelY(pixelY)
	);

	always #4 CLK = ~CLK;	// 8 ns pixel clock

	////////////////////////////////
	// Stimulus helpers
	////////////////////////////////

	function automatic logic [17:0] lfsrStep(input logic [17:0] state);
		return {state[16:0], state[17] ^ state[10]};	// Taps 18 and 11
	endfunction

	task automatic randomNibble(output logic [3:0] value);
		value = '0;
		for (int i = 0; i < 4; i++)
		begin
			value = {value[2:0], lfsrState[17]};	// One step per bit
			lfsrState = lfsrStep(lfsrState);
		end
	endtask

	// Frame 0 walks all ten digits and frame 3 keeps raw nibbles
	task automatic buildFrame(input int frame);
		logic [3:0] nib;
		int base;
		int value;
		bit anyInvalid;
		anyInvalid = 1'b0;
		randomNibble(nib);
		base = int'(nib) % 10;
		for (int k = 0; k < 18; k++)
		begin
			randomNibble(nib);
			if (frame == 0)
				value = (base + k) % 10;
			else if (frame == 3)
				value = int'(nib);
			else
				value = int'(nib) % 10;
			if (value > 9)
				anyInvalid = 1'b1;
			if (k % 2 == 0)
				curBytes[k / 2][7:4] = 4'(value);	// Tens digit
			else
				curBytes[k / 2][3:0] = 4'(value);
		end
		if (frame == 3)
		begin
			testName = "raw nibbles";
			if (!anyInvalid)
			begin
				otherErrors++;
				$display("Raw nibble frame holds no nibble above nine");
			end
		end
		else
			testName = $sformatf("digits frame %0d", frame);
	endtask

	////////////////////////////////
	// Reference model
	////////////////////////////////

	// Nibble of the cell under a screen pixel or -1 outside every cell
	function automatic int cellNibble(input int x, input int y, input logic [8:0][7:0] bytes,
		output int localX, output int localY, output int rowIdx);
		int relX;
		int relY;
		int colIdx;
		logic [7:0] pair;
		relX = x - 100;
		relY = y - 100;
		rowIdx = -1;
		colIdx = -1;
		localX = 0;
		localY = 0;
		if (relX < 0 || relY < 0 || relX >= 200 || relY >= 200)
			return -1;
		for (int r = 0; r < 3; r++)
			if (relY >= rowTops[r] && relY < rowTops[r] + 30)
			begin
				rowIdx = r;
				localY = relY - rowTops[r];
			end
		for (int c = 0; c < 6; c++)
			if (relX >= colLefts[c] && relX < colLefts[c] + 20)
			begin
				colIdx = c;
				localX = relX - colLefts[c];
			end
		if (rowIdx < 0 || colIdx < 0)
		begin
			rowIdx = -1;
			return -1;
		end
		pair = bytes[rowIdx * 3 + colIdx / 2];
		if (colIdx % 2 == 1)
			return int'(pair[3:0]);	// Odd column is units
		return int'(pair[7:4]);
	endfunction

	function automatic bit segmentLit(input int value, input int lx, input int ly);
		logic [6:0] segs;	// Bit 0 is a and bit 6 is g
		logic [6:0] hit;
		case (value)
			0: segs = 7'h3F;
			1: segs = 7'h06;
			2: segs = 7'h5B;
			3: segs = 7'h4F;
			4: segs = 7'h66;
			5: segs = 7'h6D;
			6: segs = 7'h7D;
			7: segs = 7'h07;
			8: segs = 7'h7F;
			9: segs = 7'h6F;
			default: segs = 7'h00;	// Dark above nine
		endcase
		hit[0] = (ly <= 2) && (lx >= 3) && (lx <= 16);	// a
		hit[1] = (lx >= 17) && (ly >= 3) && (ly <= 12);	// b
		hit[2] = (lx >= 17) && (ly >= 16) && (ly <= 26);	// c
		hit[3] = (ly >= 27) && (lx >= 3) && (lx <= 16);	// d
		hit[4] = (lx <= 2) && (ly >= 16) && (ly <= 26);	// e
		hit[5] = (lx <= 2) && (ly >= 3) && (ly <= 12);	// f
		hit[6] = (ly >= 13) && (ly <= 15) && (lx >= 3) && (lx <= 16);	// g
		return |(segs & hit);
	endfunction

	function automatic logic [11:0] expectedColor(input int x, input int y,
		input logic [8:0][7:0] bytes);
		int value;
		int lx;
		int ly;
		int rowIdx;
		if (x < 100 || x >= 300 || y < 100 || y >= 300)
			return 12'h000;	// Off panel
		value = cellNibble(x, y, bytes, lx, ly, rowIdx);
		if (value >= 0 && value <= 9 && segmentLit(value, lx, ly))
			return rowColors[rowIdx];
		return 12'h124;	// Panel background
	endfunction

	////////////////////////////////
	// Checkers
	////////////////////////////////

	task automatic checkResetState(input string when);
		if (colorOut !== 12'h000 || videoOn !== 1'b0 || hSyncN !== 1'b1 || vSyncN !== 1'b1)
		begin
			resetErrors++;
			$display("MISMATCH reset state %s: expected color 000 video 0 syncs 11, %s",
				when, $sformatf("actual color %h video %b syncs %b%b",
				colorOut, videoOn, hSyncN, vSyncN));
		end
	endtask

	task automatic reportTiming(input string what, input int expected, input int actual);
		timingErrors++;
		if (timingErrors <= 10)
			$display("MISMATCH raster timing %s: expected %0d actual %0d", what, expected, actual);
	endtask

	always @(negedge CLK)
	begin : compareColor
		int nibble;
		int lx;
		int ly;
		int rowIdx;
		logic [11:0] expected;
		if (checking && videoOn)
		begin
			expected = expectedColor(int'(pixelX), int'(pixelY), curBytes);
			if (colorOut !== expected)
			begin
				colorErrors++;
				if (colorErrors <= 10)
					$display("MISMATCH %s: expected %h actual %h at x %0d y %0d",
						testName, expected, colorOut, pixelX, pixelY);
			end
			nibble = cellNibble(int'(pixelX), int'(pixelY), curBytes, lx, ly, rowIdx);
			if (nibble > 9)
				invalidPixels++;
			else if (nibble >= 0)
				digitSeen[nibble] = 1'b1;
		end
		else if (checking && colorOut !== 12'h000)
		begin
			colorErrors++;
			if (colorErrors <= 10)
				$display("MISMATCH blanking: expected 000 actual %h", colorOut);
		end
	end

	always @(negedge CLK)
	begin : checkRaster
		if (checking)
		begin
			hPeriod++;
			vPeriod++;
			if (!hSyncN)
				hLowRun++;
			if (hSyncN && !prevH)	// End of horizontal pulse
			begin
				if (hLowRun != 96)
					reportTiming("hsync width", 96, hLowRun);
				hLowRun = 0;
			end
			if (!hSyncN && prevH)
			begin
				if (hFallSeen && hPeriod != lineCycles)
					reportTiming("line length", lineCycles, hPeriod);
				hPeriod = 0;
				hPulses++;
				hFallSeen = 1'b1;
			end
			if (!vSyncN)
				vLowRun++;
			if (vSyncN && !prevV)
			begin
				if (vLowRun != 2 * lineCycles)
					reportTiming("vsync width", 2 * lineCycles, vLowRun);
				vLowRun = 0;
			end
			if (videoOn)
			begin
				activeRun++;
				if (int'(pixelX) != expX)
					reportTiming("pixelX", expX, int'(pixelX));
				if (int'(pixelY) != expY)
					reportTiming("pixelY", expY, int'(pixelY));
				expX++;
			end
			if (!videoOn && prevVideo)	// End of visible line
			begin
				if (activeRun != 640)
					reportTiming("active pixels per line", 640, activeRun);
				activeRun = 0;
				activeLines++;
				expX = 0;
				expY++;
			end
			if (!vSyncN && prevV)	// Start of vertical pulse
			begin
				if (vFallSeen && vPeriod != frameCycles)
					reportTiming("frame length", frameCycles, vPeriod);
				if (vFallSeen && hPulses != frameLines)
					reportTiming("hsync pulses per frame", frameLines, hPulses);
				if (activeLines != 480)
					reportTiming("active lines per frame", 480, activeLines);
				vPeriod = 0;
				hPulses = 0;
				vFallSeen = 1'b1;
				activeLines = 0;
				expY = 0;
			end
			prevH = hSyncN;
			prevV = vSyncN;
			prevVideo = videoOn;
		end
	end

	task automatic printSummary();
		$display("Errors: reset %0d, timing %0d, color %0d, other %0d",
			resetErrors, timingErrors, colorErrors, otherErrors);
	endtask

	always @(posedge CLK)
	begin
		cycleCount++;
		if (cycleCount >= timeoutCycles)
		begin
			$display("Timed out after %0d cycles before all frames were drawn", cycleCount);
			printSummary();
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	////////////////////////////////
	// Main sequence
	////////////////////////////////

	initial
	begin
		CLK = 1'b0;
		rstN = 1'b0;
		checking = 1'b0;
		curBytes = '0;
		lfsrState = 18'd66;	// Seed
		buildFrame(0);	// Shown from the first frame
		repeat (3)
		begin
			@(posedge CLK);
			@(negedge CLK);
			checkResetState("while held");
		end
		@(posedge CLK);
		#1;
		rstN = 1'b1;	// Released after 4 cycles
		checking = 1'b1;
		@(negedge CLK);
		checkResetState("first cycle after release");
		for (int f = 1; f < 4; f++)
		begin
			@(negedge vSyncN);	// Bytes change in vertical blanking
			#1;
			buildFrame(f);
		end
		@(negedge vSyncN);	// Raw frame fully drawn
		@(negedge CLK);
		#1;
		for (int d = 0; d < 10; d++)
			if (!digitSeen[d])
			begin
				otherErrors++;
				$display("Digit value %0d was never drawn", d);
			end
		if (invalidPixels == 0)
		begin
			otherErrors++;
			$display("No pixel of a cell with a nibble above nine was checked");
		end
		printSummary();
		if (resetErrors + timingErrors + colorErrors + otherErrors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== verilog/clockDisplayTop.sv ====
// VGA clock display top level
`timescale 1ns/10ps

module clockDisplayTop #(
	parameter int hActive = 640,
	parameter int hFront = 16,
	parameter int hSync = 96,
	parameter int hBack = 48,
	parameter int vActive = 480,
	parameter int vFront = 10,
	parameter int vSync = 2,
	parameter int vBack = 33,
	parameter int panelX = 100,	// Panel placement on screen
	parameter int panelY = 100,
	parameter int panelSize = 200
)
(
	input logic CLK,	// Pixel clock
	input logic rstN,
	input clockDisplayPkg::bcdByte dayBcd,	// RTC date
	input clockDisplayPkg::bcdByte monthBcd,
	input clockDisplayPkg::bcdByte yearBcd,
	input clockDisplayPkg::bcdByte hourBcd,	// RTC time
	input clockDisplayPkg::bcdByte minuteBcd,
	input clockDisplayPkg::bcdByte secondBcd,
	input clockDisplayPkg::bcdByte timerHourBcd,	// RTC timer
	input clockDisplayPkg::bcdByte timerMinuteBcd,
	input clockDisplayPkg::bcdByte timerSecondBcd,
	output clockDisplayPkg::rgbColor colorOut,
	output logic hSyncN,
	output logic vSyncN,
	output logic videoOn,
	output clockDisplayPkg::pixelCoord pixelX,
	output clockDisplayPkg::pixelCoord pixelY
);

	clockDisplayPkg::pixelCoord hPos;	// Counter outputs
	clockDisplayPkg::pixelCoord vPos;
	logic lineSync;
	logic frameSync;
	logic activeVideo;
	logic inPanel;	// Locator outputs
	clockDisplayPkg::fieldRow row;
	clockDisplayPkg::cellCoord cellPos;
	clockDisplayPkg::bcdDigit digit;
	logic segmentOn;	// Glyph output

	vgaTiming #(
		.hActive(hActive), .hFront(hFront), .hSync(hSync), .hBack(hBack),
		.vActive(vActive), .vFront(vFront), .vSync(vSync), .vBack(vBack)
	) timingGen (
		.CLK(CLK), .rstN(rstN), .hPos(hPos), .vPos(vPos),
		.lineSync(lineSync), .frameSync(frameSync), .activeVideo(activeVideo)
	);

	digitFieldLocator #(.panelX(panelX), .panelY(panelY), .panelSize(panelSize)) locator (
		.hPos(hPos), .vPos(vPos),
		.dayBcd(dayBcd), .monthBcd(monthBcd), .yearBcd(yearBcd),
		.hourBcd(hourBcd), .minuteBcd(minuteBcd), .secondBcd(secondBcd),
		.timerHourBcd(timerHourBcd), .timerMinuteBcd(timerMinuteBcd),
		.timerSecondBcd(timerSecondBcd),
		.inPanel(inPanel), .row(row), .cellPos(cellPos), .digit(digit)
	);

	segmentGlyph glyph (.digit(digit), .cellPos(cellPos), .segmentOn(segmentOn));

	pixelCompositor compositor (
		.CLK(CLK), .rstN(rstN), .activeVideo(activeVideo),
		.lineSync(lineSync), .frameSync(frameSync), .hPos(hPos), .vPos(vPos),
		.inPanel(inPanel), .row(row), .segmentOn(segmentOn),
		.colorOut(colorOut), .hSyncN(hSyncN), .vSyncN(vSyncN),
		.videoOn(videoOn), .pixelX(pixelX), .pixelY(pixelY)
	);

endmodule

// ==== verilog/pixelCompositor.sv ====
// Pixel colour output stage
`timescale 1ns/10ps

module pixelCompositor
(
	input logic CLK,
	input logic rstN,
	input logic activeVideo,	// Visible pixel
	input logic lineSync,	// Horizontal sync, active high
	input logic frameSync,	// Vertical sync, active high
	input clockDisplayPkg::pixelCoord hPos,
	input clockDisplayPkg::pixelCoord vPos,
	input logic inPanel,
	input clockDisplayPkg::fieldRow row,
	input logic segmentOn,
	output clockDisplayPkg::rgbColor colorOut,	// Registered colour
	output logic hSyncN,	// Active low
	output logic vSyncN,	// Active low
	output logic videoOn,	// Aligned with colorOut
	output clockDisplayPkg::pixelCoord pixelX,
	output clockDisplayPkg::pixelCoord pixelY
);

	clockDisplayPkg::rgbColor nextColor;	// Colour before the register

	// Colour rule, first match wins
	always_comb
	begin
		if (!activeVideo || !inPanel)
			nextColor = clockDisplayPkg::colorBlank;	// Blanking or off-panel
		else if (segmentOn)	// Only set inside a cell with a valid digit
		begin
			case (row)
				clockDisplayPkg::rowDate: nextColor = clockDisplayPkg::colorDate;
				clockDisplayPkg::rowTime: nextColor = clockDisplayPkg::colorTime;
				clockDisplayPkg::rowTimer: nextColor = clockDisplayPkg::colorTimer;
				default: nextColor = clockDisplayPkg::colorPanel;
			endcase
		end
		else
			nextColor = clockDisplayPkg::colorPanel;	// Panel background
	end

	always_ff @(posedge CLK)
	begin
		if (!rstN)
		begin
			colorOut <= clockDisplayPkg::colorBlank;
			hSyncN <= 1'b1;	// Sync idle
			vSyncN <= 1'b1;
			videoOn <= 1'b0;
		end
		else
		begin
			colorOut <= nextColor;
			hSyncN <= ~lineSync;
			vSyncN <= ~frameSync;
			videoOn <= activeVideo;
		end
	end

	always_ff @(posedge CLK)
	begin
		pixelX <= hPos;	// Same pixel as colorOut
		pixelY <= vPos;
	end

endmodule

// ==== overlay/segmentGlyph.sv ====
// Seven-segment glyph generator
`timescale 1ns/10ps

module segmentGlyph
(
	input clockDisplayPkg::bcdDigit digit,	// Value to draw
	input clockDisplayPkg::cellCoord cellPos,	// Pixel inside the cell
	output logic segmentOn	// Pixel lies on a lit segment
);

	////////////////////////////////
	// Segment geometry
	////////////////////////////////

	localparam logic [4:0] thick = 5'(clockDisplayPkg::segThick);
	localparam logic [4:0] rightIn = 5'(clockDisplayPkg::cellWidth - clockDisplayPkg::segThick);
	localparam logic [4:0] bottomIn =
		5'(clockDisplayPkg::cellHeight - clockDisplayPkg::segThick);	// Top of segment d
	localparam logic [4:0] midTop =
		5'((clockDisplayPkg::cellHeight - clockDisplayPkg::segThick) / 2);	// Top of segment g
	localparam logic [4:0] midEnd = midTop + thick;	// First row below g

	logic [6:0] litMask;	// Segments a..g, a is MSB
	logic [6:0] region;	// Segment areas that hold the pixel
	logic inBarX;	// Between the vertical strokes
	logic leftCol;
	logic rightCol;
	logic upperHalf;	// Between a and g
	logic lowerHalf;	// Between g and d

	// Standard patterns, anything above nine stays dark
	always_comb
	begin
		case (digit)
			4'd0: litMask = 7'b1111110;
			4'd1: litMask = 7'b0110000;
			4'd2: litMask = 7'b1101101;
			4'd3: litMask = 7'b1111001;
			4'd4: litMask = 7'b0110011;
			4'd5: litMask = 7'b1011011;
			4'd6: litMask = 7'b1011111;
			4'd7: litMask = 7'b1110000;
			4'd8: litMask = 7'b1111111;
			4'd9: litMask = 7'b1111011;
			default: litMask = 7'b0000000;
		endcase
	end

	assign inBarX = (cellPos.x >= thick) && (cellPos.x < rightIn);	// Columns 3..16
	assign leftCol = (cellPos.x < thick);	// Columns 0..2
	assign rightCol = (cellPos.x >= rightIn);	// Columns 17..19
	assign upperHalf = (cellPos.y >= thick) && (cellPos.y < midTop);	// Rows 3..12
	assign lowerHalf = (cellPos.y >= midEnd) && (cellPos.y < bottomIn);	// Rows 16..26

	assign region[6] = inBarX && (cellPos.y < thick);	// a
	assign region[5] = rightCol && upperHalf;	// b
	assign region[4] = rightCol && lowerHalf;	// c
	assign region[3] = inBarX && (cellPos.y >= bottomIn);	// d
	assign region[2] = leftCol && lowerHalf;	// e
	assign region[1] = leftCol && upperHalf;	// f
	assign region[0] = inBarX && (cellPos.y >= midTop) && (cellPos.y < midEnd);	// g

	assign segmentOn = |(litMask & region);

endmodule

// ==== overlay/digitFieldLocator.sv ====
// Panel and digit cell locator
`timescale 1ns/10ps

module digitFieldLocator #(
	parameter int panelX = 100,	// Panel left edge on screen
	parameter int panelY = 100,	// Panel top edge on screen
	parameter int panelSize = 200	// Panel is square
)
(
	input clockDisplayPkg::pixelCoord hPos,	// Screen column
	input clockDisplayPkg::pixelCoord vPos,	// Screen line
	input clockDisplayPkg::bcdByte dayBcd,
	input clockDisplayPkg::bcdByte monthBcd,
	input clockDisplayPkg::bcdByte yearBcd,
	input clockDisplayPkg::bcdByte hourBcd,
	input clockDisplayPkg::bcdByte minuteBcd,
	input clockDisplayPkg::bcdByte secondBcd,
	input clockDisplayPkg::bcdByte timerHourBcd,
	input clockDisplayPkg::bcdByte timerMinuteBcd,
	input clockDisplayPkg::bcdByte timerSecondBcd,
	output logic inPanel,	// Pixel inside panel window
	output clockDisplayPkg::fieldRow row,	// Row of the cell, rowNone if none
	output clockDisplayPkg::cellCoord cellPos,	// Position inside the cell
	output clockDisplayPkg::bcdDigit digit	// Nibble for the cell, F if none
);

	localparam clockDisplayPkg::pixelCoord panelLeft = clockDisplayPkg::pixelCoord'(panelX);
	localparam clockDisplayPkg::pixelCoord panelTop = clockDisplayPkg::pixelCoord'(panelY);
	localparam clockDisplayPkg::pixelCoord panelRight =
		clockDisplayPkg::pixelCoord'(panelX + panelSize);	// First column past the panel
	localparam clockDisplayPkg::pixelCoord panelBottom =
		clockDisplayPkg::pixelCoord'(panelY + panelSize);	// First line past the panel
	localparam clockDisplayPkg::pixelCoord width =
		clockDisplayPkg::pixelCoord'(clockDisplayPkg::cellWidth);
	localparam clockDisplayPkg::pixelCoord height =
		clockDisplayPkg::pixelCoord'(clockDisplayPkg::cellHeight);

	clockDisplayPkg::pixelCoord relX;	// Panel relative column
	clockDisplayPkg::pixelCoord relY;	// Panel relative line
	clockDisplayPkg::bcdByte rowBytes [3][3];	// Bytes per row, left to right

	////////////////////////////////
	// Byte layout
	////////////////////////////////

	assign rowBytes[0][0] = dayBcd;
	assign rowBytes[0][1] = monthBcd;
	assign rowBytes[0][2] = yearBcd;
	assign rowBytes[1][0] = hourBcd;
	assign rowBytes[1][1] = minuteBcd;
	assign rowBytes[1][2] = secondBcd;
	assign rowBytes[2][0] = timerHourBcd;
	assign rowBytes[2][1] = timerMinuteBcd;
	assign rowBytes[2][2] = timerSecondBcd;

	// Half-open window, left and top edges included
	assign inPanel = (hPos >= panelLeft) && (hPos < panelRight) &&
		(vPos >= panelTop) && (vPos < panelBottom);
	assign relX = hPos - panelLeft;
	assign relY = vPos - panelTop;

	////////////////////////////////
	// Cell search
	////////////////////////////////

	always_comb
	begin
		clockDisplayPkg::pixelCoord edgeAt;	// Offset under test
		clockDisplayPkg::pixelCoord rowTop;	// Top of matched row
		clockDisplayPkg::pixelCoord colLeft;	// Left of matched column
		clockDisplayPkg::pixelCoord dx;
		clockDisplayPkg::pixelCoord dy;
		clockDisplayPkg::bcdByte byteSel;	// Byte feeding this cell
		logic [1:0] rowIdx;
		logic [2:0] colIdx;
		logic rowHit;
		logic colHit;

		rowHit = 1'b0;
		rowIdx = '0;
		rowTop = '0;
		for (int r = 0; r < 3; r++)
		begin
			edgeAt = clockDisplayPkg::pixelCoord'(clockDisplayPkg::rowOffsetY[r]);
			if (relY >= edgeAt && relY < edgeAt + height)	// Rows never overlap
			begin
				rowHit = 1'b1;
				rowIdx = 2'(r);
				rowTop = edgeAt;
			end
		end

		colHit = 1'b0;
		colIdx = '0;
		colLeft = '0;
		for (int c = 0; c < 6; c++)
		begin
			edgeAt = clockDisplayPkg::pixelCoord'(clockDisplayPkg::colOffsetX[c]);
			if (relX >= edgeAt && relX < edgeAt + width)
			begin
				colHit = 1'b1;
				colIdx = 3'(c);
				colLeft = edgeAt;
			end
		end

		dx = relX - colLeft;
		dy = relY - rowTop;
		byteSel = rowBytes[rowIdx][colIdx[2:1]];	// Two columns per byte

		if (inPanel && rowHit && colHit)
		begin
			row = clockDisplayPkg::fieldRow'(rowIdx);
			cellPos.x = dx[4:0];
			cellPos.y = dy[4:0];
			digit = colIdx[0] ? byteSel[3:0] : byteSel[7:4];	// Even column is tens
		end
		else
		begin
			row = clockDisplayPkg::rowNone;	// Background pixel
			cellPos = '0;
			digit = 4'hF;
		end
	end

endmodule

// ==== vgaTiming/vgaTiming.sv ====
// VGA raster timing generator
`timescale 1ns/10ps

module vgaTiming #(
	parameter int hActive = 640,	// Visible pixels per line
	parameter int hFront = 16,	// Horizontal front porch
	parameter int hSync = 96,	// Horizontal sync width
	parameter int hBack = 48,	// Horizontal back porch
	parameter int vActive = 480,	// Visible lines per frame
	parameter int vFront = 10,	// Vertical front porch
	parameter int vSync = 2,	// Vertical sync width in lines
	parameter int vBack = 33	// Vertical back porch
)
(
	input logic CLK,	// Pixel clock
	input logic rstN,	// Sync reset, active low
	output clockDisplayPkg::pixelCoord hPos,	// Current column
	output clockDisplayPkg::pixelCoord vPos,	// Current line
	output logic lineSync,	// Horizontal sync, active high
	output logic frameSync,	// Vertical sync, active high
	output logic activeVideo	// Both axes visible
);

	////////////////////////////////
	// Phase boundaries
	////////////////////////////////

	localparam clockDisplayPkg::pixelCoord hFrontStart =
		clockDisplayPkg::pixelCoord'(hActive);
	localparam clockDisplayPkg::pixelCoord hSyncStart =
		clockDisplayPkg::pixelCoord'(hActive + hFront);
	localparam clockDisplayPkg::pixelCoord hBackStart =
		clockDisplayPkg::pixelCoord'(hActive + hFront + hSync);
	localparam clockDisplayPkg::pixelCoord hLast =
		clockDisplayPkg::pixelCoord'(hActive + hFront + hSync + hBack - 1);	// 799 by default

	localparam clockDisplayPkg::pixelCoord vFrontStart =
		clockDisplayPkg::pixelCoord'(vActive);
	localparam clockDisplayPkg::pixelCoord vSyncStart =
		clockDisplayPkg::pixelCoord'(vActive + vFront);
	localparam clockDisplayPkg::pixelCoord vBackStart =
		clockDisplayPkg::pixelCoord'(vActive + vFront + vSync);
	localparam clockDisplayPkg::pixelCoord vLast =
		clockDisplayPkg::pixelCoord'(vActive + vFront + vSync + vBack - 1);	// 524 by default

	clockDisplayPkg::pixelCoord hCount;	// Column counter
	clockDisplayPkg::pixelCoord vCount;	// Line counter
	clockDisplayPkg::timingPhase hPhase;	// Horizontal phase
	clockDisplayPkg::timingPhase vPhase;	// Vertical phase

	// Same decode for both axes, only the boundaries differ
	function automatic clockDisplayPkg::timingPhase decodePhase
	(
		input clockDisplayPkg::pixelCoord pos,
		input clockDisplayPkg::pixelCoord frontStart,
		input clockDisplayPkg::pixelCoord syncStart,
		input clockDisplayPkg::pixelCoord backStart
	);
		if (pos < frontStart)
			return clockDisplayPkg::active;
		else if (pos < syncStart)
			return clockDisplayPkg::frontPorch;
		else if (pos < backStart)
			return clockDisplayPkg::syncPulse;
		else
			return clockDisplayPkg::backPorch;
	endfunction

	////////////////////////////////
	// Counters
	////////////////////////////////

	always_ff @(posedge CLK)
	begin
		if (!rstN)
		begin
			hCount <= '0;	// Start of frame
			vCount <= '0;
		end
		else if (hCount == hLast)	// End of line
		begin
			hCount <= '0;
			if (vCount == vLast)	// End of frame
				vCount <= '0;
			else
				vCount <= vCount + 1'b1;	// Next line
		end
		else
			hCount <= hCount + 1'b1;	// Next pixel
	end

	////////////////////////////////
	// Decode
	////////////////////////////////

	always_comb
	begin
		hPhase = decodePhase(hCount, hFrontStart, hSyncStart, hBackStart);
		vPhase = decodePhase(vCount, vFrontStart, vSyncStart, vBackStart);
	end

	assign hPos = hCount;
	assign vPos = vCount;
	assign lineSync = (hPhase == clockDisplayPkg::syncPulse);	// Inside horizontal pulse
	assign frameSync = (vPhase == clockDisplayPkg::syncPulse);	// Inside vertical pulse
	assign activeVideo = (hPhase == clockDisplayPkg::active) &&
		(vPhase == clockDisplayPkg::active);	// Visible in both axes

endmodule

// ==== common/clockDisplayPkg.sv ====
// Clock display shared definitions

package clockDisplayPkg;

	////////////////////////////////
	// Basic data types
	////////////////////////////////

	typedef logic [9:0] pixelCoord;	// Screen or panel coordinate
	typedef logic [11:0] rgbColor;	// 4 bits each of R, G, B
	typedef logic [7:0] bcdByte;	// Two BCD digits, tens first
	typedef logic [3:0] bcdDigit;	// One BCD nibble

	typedef struct packed
	{
		logic [4:0] x;	// Column inside the digit cell
		logic [4:0] y;	// Row inside the digit cell
	} cellCoord;

	////////////////////////////////
	// Enums
	////////////////////////////////

	// Phase of one raster axis, in counting order
	typedef enum logic [1:0]
	{
		active = 2'd0,	// Visible region
		frontPorch = 2'd1,	// Gap before sync
		syncPulse = 2'd2,	// Sync asserted
		backPorch = 2'd3	// Gap after sync
	} timingPhase;

	// Panel row that a pixel falls in, order matches rowOffsetY
	typedef enum logic [1:0]
	{
		rowDate = 2'd0,	// Day, month, year
		rowTime = 2'd1,	// Hour, minute, second
		rowTimer = 2'd2,	// Timer hour, minute, second
		rowNone = 2'd3	// Outside every digit cell
	} fieldRow;

	////////////////////////////////
	// Panel layout
	////////////////////////////////

	localparam int cellWidth = 20;	// Digit cell width in pixels
	localparam int cellHeight = 30;	// Digit cell height in pixels
	localparam int segThick = 3;	// Segment stroke width

	localparam int rowOffsetY [3] = '{21, 71, 141};	// Top of each row, panel relative
	localparam int colOffsetX [6] = '{21, 46, 81, 106, 141, 166};	// Left of each column

	////////////////////////////////
	// Colours
	////////////////////////////////

	localparam rgbColor colorBlank = 12'h000;	// Blanking and off-panel
	localparam rgbColor colorPanel = 12'h124;	// Panel background
	localparam rgbColor colorDate = 12'hFFF;	// White
	localparam rgbColor colorTime = 12'h0F0;	// Green
	localparam rgbColor colorTimer = 12'hFA0;	// Amber

endpackage
